/* Makefile */
# Verilator build for the output port arbiter.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tbOutputArbiter
FILELIST  ?= outputArbiter.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

FAIL_MSG := TESTBENCH FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ]; then \
		echo "simulation exited with status $$status"; \
		exit 1; \
	fi; \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "failure found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* outputArbiter.f */
rtl/routerPkg.sv
rtl/holdTimer.sv
rtl/grantFsm.sv
rtl/flitSwitch.sv
rtl/outputArbiter.sv
testbench/tbOutputArbiter.sv

/* rtl/flitSwitch.sv */
`timescale 1ns/1ns

module flitSwitch import routerPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  portT                 grant,
  input  logic [FlitWidth-1:0] lFlit,
  input  logic [FlitWidth-1:0] nFlit,
  input  logic [FlitWidth-1:0] eFlit,
  input  logic [FlitWidth-1:0] wFlit,
  input  logic [FlitWidth-1:0] sFlit,
  output logic [FlitWidth-1:0] outFlit,
  output logic                 outValid,
  output portT                 outSrc
);

  logic [FlitWidth-1:0] selFlit;

  always_comb
  begin
    case (grant)
      portL:
        selFlit = lFlit;
      portN:
        selFlit = nFlit;
      portE:
        selFlit = eFlit;
      portW:
        selFlit = wFlit;
      portS:
        selFlit = sFlit;
      default:
        selFlit = '0; // the data lines read zero while the port is idle.
    endcase
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outSrc <= portIdle;
    end
    else
    begin
      outValid <= (grant != portIdle);
      outSrc <= grant; // source travels with the flit through the register.
    end
  end

  assert property (@(posedge clk) disable iff (rst) outValid |-> (outSrc != portIdle))
    else $error("flitSwitch: valid output without a granted source.");

endmodule

/* rtl/grantFsm.sv */
`timescale 1ns/1ns

module grantFsm import routerPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NumPorts-1:0] req,
  input  logic [NumPorts-1:0] timesUp,
  output logic [NumPorts-1:0] runTimer,
  output portT                grant
);

  portT                state;
  portT                nextState;
  logic [NumPorts-1:0] owner;     // current owner as a channel vector with L in bit zero.
  logic [NumPorts-1:0] keep;      // owner still requesting with time left.
  int unsigned         scanStart; // channel where the rotating search begins.

  // first requesting channel at or after start with a wrap from S back to L.
  function automatic portT pickFrom
  (
    input logic [NumPorts-1:0] reqs,
    input int unsigned         start
  );
    portT        found;
    int unsigned idx;
    found = portIdle;
    for (int i = NumPorts - 1; i >= 0; i--)
    begin
      idx = start + i;
      if (idx >= NumPorts)
      begin
        idx = idx - NumPorts;
      end
      if (reqs[idx])
      begin
        found = portT'(6'b000010 << idx); // lower offsets are scanned last and win.
      end
    end
    return found;
  endfunction

  assign owner = state[NumPorts:1];
  assign keep = owner & req & ~timesUp;

  always_comb
  begin
    case (state)
      portL:
        scanStart = 1;
      portN:
        scanStart = 2;
      portE:
        scanStart = 3;
      portW:
        scanStart = 4;
      default:
        scanStart = 0; // S wraps to L, and idle starts at L.
    endcase
  end

  always_comb
  begin
    runTimer = '0;
    nextState = portIdle;
    case (state)
      portIdle:
      begin
        nextState = pickFrom(req, 0); // fixed priority L, N, E, W, S.
      end
      portL, portN, portE, portW, portS:
      begin
        if (keep != '0)
        begin
          runTimer = keep;
          nextState = state;
        end
        else
        begin
          // the owner itself comes last in its own rotation.
          nextState = pickFrom(req, scanStart);
        end
      end
      default:
      begin
        nextState = portIdle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= portIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state;

  assert property (@(posedge clk) disable iff (rst) $onehot0(runTimer))
    else $error("grantFsm: more than one hold timer running.");

  // a running timer belongs to the channel that owns the port.
  assert property (@(posedge clk) disable iff (rst) (runTimer != '0) |-> (runTimer == owner))
    else $error("grantFsm: hold timer running for a channel that does not own the port.");

endmodule

/* rtl/holdTimer.sv */
`timescale 1ns/1ns

module holdTimer import routerPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  flitIdT                 flitId,
  input  logic [LengthWidth-1:0] length,
  input  logic                   runTimer,
  output logic                   timesUp
);

  logic [LengthWidth-1:0] limit; // hold limit taken from the last head flit.
  logic [LengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == flitHead)
      begin
        limit <= length;
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0; // the count restarts whenever the channel is not holding.
      end
    end
  end

  assign timesUp = (count == limit);

  // The grant machine stops the timer in the cycle the count reaches the limit,
  // so a running count never steps past the limit.
  assert property (@(posedge clk) disable iff (rst) runTimer |-> (count != limit))
    else $error("holdTimer: count ran past the hold limit.");

endmodule

/* rtl/outputArbiter.sv */
`timescale 1ns/1ns

module outputArbiter import routerPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [FlitWidth-1:0]   lFlit,
  input  flitIdT                 lFlitId,
  input  logic [LengthWidth-1:0] lLength,
  input  logic                   lReq,
  input  logic [FlitWidth-1:0]   nFlit,
  input  flitIdT                 nFlitId,
  input  logic [LengthWidth-1:0] nLength,
  input  logic                   nReq,
  input  logic [FlitWidth-1:0]   eFlit,
  input  flitIdT                 eFlitId,
  input  logic [LengthWidth-1:0] eLength,
  input  logic                   eReq,
  input  logic [FlitWidth-1:0]   wFlit,
  input  flitIdT                 wFlitId,
  input  logic [LengthWidth-1:0] wLength,
  input  logic                   wReq,
  input  logic [FlitWidth-1:0]   sFlit,
  input  flitIdT                 sFlitId,
  input  logic [LengthWidth-1:0] sLength,
  input  logic                   sReq,
  output logic [FlitWidth-1:0]   outFlit,
  output logic                   outValid,
  output portT                   outSrc
);

  logic [NumPorts-1:0] req;      // channel vectors are L, N, E, W, S from bit zero up.
  logic [NumPorts-1:0] runTimer;
  logic [NumPorts-1:0] timesUp;
  portT                grant;

  assign req = {sReq, wReq, eReq, nReq, lReq};

  holdTimer lTimer
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (lFlitId),
    .length   (lLength),
    .runTimer (runTimer[0]),
    .timesUp  (timesUp[0])
  );

  holdTimer nTimer
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (nFlitId),
    .length   (nLength),
    .runTimer (runTimer[1]),
    .timesUp  (timesUp[1])
  );

  holdTimer eTimer
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (eFlitId),
    .length   (eLength),
    .runTimer (runTimer[2]),
    .timesUp  (timesUp[2])
  );

  holdTimer wTimer
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (wFlitId),
    .length   (wLength),
    .runTimer (runTimer[3]),
    .timesUp  (timesUp[3])
  );

  holdTimer sTimer
  (
    .clk      (clk),
    .rst      (rst),
    .flitId   (sFlitId),
    .length   (sLength),
    .runTimer (runTimer[4]),
    .timesUp  (timesUp[4])
  );

  grantFsm fsm
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .timesUp  (timesUp),
    .runTimer (runTimer),
    .grant    (grant)
  );

  flitSwitch switch
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .lFlit    (lFlit),
    .nFlit    (nFlit),
    .eFlit    (eFlit),
    .wFlit    (wFlit),
    .sFlit    (sFlit),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outSrc   (outSrc)
  );

endmodule

/* rtl/routerPkg.sv */
package routerPkg;

  // number of input channels competing for this output port.
  localparam int NumPorts = 5;

  localparam int FlitWidth = 32;   // payload width of one flit.
  localparam int LengthWidth = 12; // packet length field and also the hold counter width.
  localparam int FlitIdWidth = 3;

  // owner of the output port.
  // It is one-hot with idle in bit zero, so bits 5:1 line up with the channels L, N, E, W, S.
  typedef enum logic [NumPorts:0]
  {
    portIdle = 6'b000001,
    portL    = 6'b000010,
    portN    = 6'b000100,
    portE    = 6'b001000,
    portW    = 6'b010000,
    portS    = 6'b100000
  } portT;

  typedef enum logic [FlitIdWidth-1:0]
  {
    flitBody = 3'd0,
    flitHead = 3'd1, // the head flit carries the packet length.
    flitTail = 3'd2
  } flitIdT;

endpackage

/* testbench/tbOutputArbiter.sv */
`timescale 1ns/1ns

module tbOutputArbiter import routerPkg::*;
();

  localparam int ClockPeriod = 10;
  localparam int DriveDelay = 1;
  localparam int ResetCycles = 10;
  localparam int DirectedCycles = 110;
  localparam int RandomCycles = 400;
  localparam int WatchdogNs = (ResetCycles + DirectedCycles + RandomCycles) * 3 / 2 * ClockPeriod;

  logic                   clk;
  logic                   rst;
  logic [FlitWidth-1:0]   chanFlit [NumPorts];   // channel arrays run L, N, E, W, S.
  flitIdT                 chanId [NumPorts];
  logic [LengthWidth-1:0] chanLength [NumPorts];
  logic [NumPorts-1:0]    chanReq;
  logic [FlitWidth-1:0]   outFlit;
  logic                   outValid;
  portT                   outSrc;

  int                     expOwner;              // -1 while the port is idle.
  portT                   expOutSrc;
  logic                   expOutValid;
  logic [FlitWidth-1:0]   expOutFlit;
  logic [LengthWidth-1:0] holdLimit [NumPorts];
  logic [LengthWidth-1:0] holdCount [NumPorts];
  logic                   checkOn = 1'b0;
  int                     mismatchCount = 0;
  int                     otherCount = 0;
  int                     validCycles = 0;
  int                     cycle = 0;
  integer                 seed;
  string                  testName = "reset";

  outputArbiter outputArbiter_inst
  (
    .clk      (clk),
    .rst      (rst),
    .lFlit    (chanFlit[0]),
    .lFlitId  (chanId[0]),
    .lLength  (chanLength[0]),
    .lReq     (chanReq[0]),
    .nFlit    (chanFlit[1]),
    .nFlitId  (chanId[1]),
    .nLength  (chanLength[1]),
    .nReq     (chanReq[1]),
    .eFlit    (chanFlit[2]),
    .eFlitId  (chanId[2]),
    .eLength  (chanLength[2]),
    .eReq     (chanReq[2]),
    .wFlit    (chanFlit[3]),
    .wFlitId  (chanId[3]),
    .wLength  (chanLength[3]),
    .wReq     (chanReq[3]),
    .sFlit    (chanFlit[4]),
    .sFlitId  (chanId[4]),
    .sLength  (chanLength[4]),
    .sReq     (chanReq[4]),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outSrc   (outSrc)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClockPeriod / 2) clk = ~clk;
  end

  // scans the channels from start on and wraps; the first requester found wins.
  function automatic int firstRequester(input logic [NumPorts-1:0] reqs, input int start);
    int found;
    int ch;
    found = -1;
    for (int offset = 0; offset < NumPorts; offset++)
    begin
      ch = (start + offset) % NumPorts;
      if (found < 0 && reqs[ch])
      begin
        found = ch;
      end
    end
    return found;
  endfunction

  function automatic portT ownerToPort(input int owner);
    portT port;
    case (owner)
      0: port = portL;
      1: port = portN;
      2: port = portE;
      3: port = portW;
      4: port = portS;
      default: port = portIdle;
    endcase
    return port;
  endfunction

  // reference model of the grant rule with one edge for the grant and one more for the output.
  always @(posedge clk)
  begin : grantModel
    int nextOwner;
    int running;
    checkOn <= 1'b1;
    if (outValid === 1'b1)
    begin
      validCycles++;
    end
    if (rst)
    begin
      expOwner <= -1;
      expOutSrc <= portIdle;
      expOutValid <= 1'b0;
      expOutFlit <= '0;
      for (int ch = 0; ch < NumPorts; ch++)
      begin
        holdLimit[ch] <= '0;
        holdCount[ch] <= '0;
      end
    end
    else
    begin
      running = -1;
      if (expOwner < 0)
      begin
        nextOwner = firstRequester(chanReq, 0);
      end
      else if (chanReq[expOwner] && (holdCount[expOwner] != holdLimit[expOwner]))
      begin
        nextOwner = expOwner; // owner keeps the port while it asks and has time left.
        running = expOwner;
      end
      else
      begin
        nextOwner = firstRequester(chanReq, (expOwner + 1) % NumPorts);
      end
      for (int ch = 0; ch < NumPorts; ch++)
      begin
        if (chanId[ch] == flitHead)
        begin
          holdLimit[ch] <= chanLength[ch];
        end
        holdCount[ch] <= (ch == running) ? holdCount[ch] + 1'b1 : '0;
      end
      expOwner <= nextOwner;
      expOutSrc <= ownerToPort(expOwner);
      expOutValid <= (expOwner >= 0);
      expOutFlit <= (expOwner >= 0) ? chanFlit[expOwner] : '0;
    end
  end

  assert property (@(posedge clk) (checkOn && rst) |-> (!outValid && outSrc == portIdle))
    else
    begin
      mismatchCount++;
      $display("FAILED %s: reset outValid/outSrc expected 0/%b, actual %b/%b", testName,
        portIdle, $sampled(outValid), $sampled(outSrc));
    end

  assert property (@(posedge clk) checkOn |-> (outSrc == expOutSrc))
    else
    begin
      mismatchCount++;
      $display("FAILED %s: outSrc expected %b, actual %b", testName, $sampled(expOutSrc),
        $sampled(outSrc));
    end

  assert property (@(posedge clk) checkOn |-> (outValid == expOutValid))
    else
    begin
      mismatchCount++;
      $display("FAILED %s: outValid expected %b, actual %b", testName, $sampled(expOutValid),
        $sampled(outValid));
    end

  assert property (@(posedge clk) (checkOn && outValid && expOutValid) |-> (outFlit == expOutFlit))
    else
    begin
      mismatchCount++;
      $display("FAILED %s: outFlit expected %h, actual %h", testName, $sampled(expOutFlit),
        $sampled(outFlit));
    end

  task automatic waitEdge();
    @(posedge clk);
    #DriveDelay;
    cycle++;
  endtask

  // each channel's flit carries its channel number and the cycle, so a wrong source shows up.
  task automatic runCycles(input int n);
    repeat (n)
    begin
      waitEdge();
      for (int ch = 0; ch < NumPorts; ch++)
      begin
        chanFlit[ch] = {8'(ch + 1), 24'(cycle)};
      end
    end
  endtask

  task automatic loadHeads(input logic [NumPorts-1:0] mask, input logic [LengthWidth-1:0] len);
    for (int ch = 0; ch < NumPorts; ch++)
    begin
      if (mask[ch])
      begin
        chanId[ch] = flitHead;
        chanLength[ch] = len;
      end
    end
    runCycles(1);
    for (int ch = 0; ch < NumPorts; ch++)
    begin
      chanId[ch] = flitBody;
    end
  endtask

  task automatic raiseTogether(input logic [NumPorts-1:0] mask);
    chanReq = mask;
    runCycles(6);
    chanReq = '0;
    runCycles(4);
  endtask

  task automatic randomizeInputs();
    int pick;
    for (int ch = 0; ch < NumPorts; ch++)
    begin
      chanReq[ch] = (($random(seed) & 3) != 0);
      pick = $random(seed) & 7;
      chanId[ch] = (pick == 0) ? flitHead : ((pick == 1) ? flitTail : flitBody);
      chanLength[ch] = LengthWidth'($random(seed) & 7);
      chanFlit[ch] = $random(seed);
    end
  endtask

  initial
  begin : stimulus
    seed = 32'h6df9;
    rst = 1'b1;
    chanReq = '0;
    for (int ch = 0; ch < NumPorts; ch++)
    begin
      chanFlit[ch] = '0;
      chanId[ch] = flitBody;
      chanLength[ch] = '0;
    end
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rst = 1'b0;
    runCycles(2);

    testName = "idlePriority";
    loadHeads(5'b11111, 12'd2);
    raiseTogether(5'b11100); // E, W and S together, so E wins.
    raiseTogether(5'b10110);
    raiseTogether(5'b11111);

    testName = "holdLength";
    loadHeads(5'b01000, 12'd5);
    chanReq = 5'b01000;
    runCycles(2);
    chanReq = 5'b11111; // W keeps the port for six cycles against everyone.
    runCycles(12);
    chanReq = '0;
    runCycles(4);

    testName = "rotation";
    loadHeads(5'b11111, 12'd1);
    chanReq = 5'b11111;
    runCycles(30);
    chanReq = '0;
    runCycles(4);

    testName = "releaseOnDrop";
    loadHeads(5'b00110, 12'd20);
    chanReq = 5'b00110;
    runCycles(4);
    chanReq = 5'b00100; // N leaves early and E takes over.
    runCycles(4);
    chanReq = '0;
    runCycles(4);

    testName = "randomTraffic";
    repeat (RandomCycles)
    begin
      waitEdge();
      randomizeInputs();
    end
    chanReq = '0;
    runCycles(4);

    if (validCycles == 0)
    begin
      otherCount++;
      $display("no valid output was seen during the whole run.");
    end
    $display("errors: %0d wrong values, %0d other failures", mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial
  begin : watchdog
    #WatchdogNs;
    $display("watchdog: the run did not finish within %0d ns.", WatchdogNs);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
